// File: filelist.f
hw/isa_pkg.sv
hw/issue_pkg.sv
hw/slot_select.sv
hw/issue_sched.sv
hw/pipe_tracker.sv
hw/regfile.sv
hw/operand_bypass.sv
hw/issue_top.sv
tests/issue_assert.sv
tests/issue_tb.sv

// File: hw/isa_pkg.sv
// RISC-V ISA definitions
// Register file geometry, register field positions in the 32-bit
// encoding and the execution classes seen by the issue stage
package isa_pkg;

    //----------------------------------------
    // Data path
    //----------------------------------------
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_REGS  = 1 << REG_IDX_W;

    //----------------------------------------
    // Register fields
    //----------------------------------------
    // Each field is REG_IDX_W bits wide
    localparam int RD_LSB = 7;
    localparam int RA_LSB = 15;
    localparam int RB_LSB = 20;

    // Execution class of a fetched word
    typedef enum logic [1:0] {
        CLASS_ALU   = 2'd0,
        CLASS_LOAD  = 2'd1,
        CLASS_STORE = 2'd2
    } instr_class_e;

endpackage

// File: hw/issue_pkg.sv
// Issue stage definitions
// Reset PC, PC step and the records passed between the fetch
// selection, the scheduler, the pipe trackers and the issue outputs
package issue_pkg;

    localparam logic [isa_pkg::XLEN-1:0] RESET_PC    = '0;
    localparam logic [isa_pkg::XLEN-1:0] INSTR_BYTES = 'd4;

    //----------------------------------------
    // Front end records
    //----------------------------------------
    // One word from the fetch unit
    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] instr;
        logic [isa_pkg::XLEN-1:0] pc;
        isa_pkg::instr_class_e    iclass;
    } fetch_word_t;

    // One selected slot, not yet cleared for issue
    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] instr;
        logic [isa_pkg::XLEN-1:0] pc;
        isa_pkg::instr_class_e    iclass;
    } slot_op_t;

    // Issued op with its operands
    typedef struct packed {
        logic                     valid;
        logic [isa_pkg::XLEN-1:0] instr;
        logic [isa_pkg::XLEN-1:0] pc;
        logic [isa_pkg::XLEN-1:0] ra_value;
        logic [isa_pkg::XLEN-1:0] rb_value;
    } issue_op_t;

    //----------------------------------------
    // Pipe stage record
    //----------------------------------------
    typedef struct packed {
        logic                          valid;
        logic                          is_load;
        logic                          writes_rd;
        logic [isa_pkg::REG_IDX_W-1:0] rd;
        logic [isa_pkg::XLEN-1:0]      result;
    } stage_t;

endpackage

// File: hw/issue_sched.sv
// Issue scheduler
// Scoreboard over in-flight loads and same-cycle dependencies,
// pairing rules for the second slot and the per-slot issue strobes
`timescale 1ns/100ps

module issue_sched
(
    input  issue_pkg::slot_op_t slot_a_i,
    input  issue_pkg::slot_op_t slot_b_i,
    input  issue_pkg::stage_t   p0_e1_i,
    input  issue_pkg::stage_t   p0_e2_i,
    input  issue_pkg::stage_t   p1_e1_i,
    input  issue_pkg::stage_t   p1_e2_i,
    output logic                issue_a_o,
    output logic                issue_b_o
);

    logic [isa_pkg::NUM_REGS-1:0]  sb_a;
    logic [isa_pkg::NUM_REGS-1:0]  sb_b;
    logic [isa_pkg::REG_IDX_W-1:0] a_ra;
    logic [isa_pkg::REG_IDX_W-1:0] a_rb;
    logic [isa_pkg::REG_IDX_W-1:0] a_rd;
    logic [isa_pkg::REG_IDX_W-1:0] b_ra;
    logic [isa_pkg::REG_IDX_W-1:0] b_rb;
    logic [isa_pkg::REG_IDX_W-1:0] b_rd;
    logic                          a_writes;
    logic                          pair_ok;

    // Destination of an in-flight op whose result cannot be forwarded yet
    function automatic logic [isa_pkg::NUM_REGS-1:0] pending(
        input issue_pkg::stage_t st,
        input logic              ready
    );
        logic [isa_pkg::NUM_REGS-1:0] mask;
        mask = '0;
        if (st.valid && st.writes_rd && !ready)
            mask[st.rd] = 1'b1;
        return mask;
    endfunction

    assign a_ra = slot_a_i.instr[isa_pkg::RA_LSB +: isa_pkg::REG_IDX_W];
    assign a_rb = slot_a_i.instr[isa_pkg::RB_LSB +: isa_pkg::REG_IDX_W];
    assign a_rd = slot_a_i.instr[isa_pkg::RD_LSB +: isa_pkg::REG_IDX_W];
    assign b_ra = slot_b_i.instr[isa_pkg::RA_LSB +: isa_pkg::REG_IDX_W];
    assign b_rb = slot_b_i.instr[isa_pkg::RB_LSB +: isa_pkg::REG_IDX_W];
    assign b_rd = slot_b_i.instr[isa_pkg::RD_LSB +: isa_pkg::REG_IDX_W];

    assign a_writes = (slot_a_i.iclass != isa_pkg::CLASS_STORE) && (a_rd != '0);

    // Slot B is ALU only, behind an ALU op or a load
    assign pair_ok = (slot_b_i.iclass == isa_pkg::CLASS_ALU) &&
                     (slot_a_i.iclass != isa_pkg::CLASS_STORE);

    //----------------------------------------
    // Scoreboard
    //----------------------------------------
    // Load data shows up in E2, so only loads in E1 hold an op back
    assign sb_a = pending(p0_e1_i, !p0_e1_i.is_load) |
                  pending(p1_e1_i, !p1_e1_i.is_load);

    always_comb
    begin
        sb_b = sb_a;
        // Slot B cannot see slot A's result in the same cycle
        if (issue_a_o && a_writes)
            sb_b[a_rd] = 1'b1;
    end

    //----------------------------------------
    // Issue decisions
    //----------------------------------------
    assign issue_a_o = slot_a_i.valid && !(sb_a[a_ra] || sb_a[a_rb] || sb_a[a_rd]);

    assign issue_b_o = issue_a_o && slot_b_i.valid && pair_ok &&
                       !(sb_b[b_ra] || sb_b[b_rb] || sb_b[b_rd]);

endmodule

// File: hw/issue_top.sv
// Dual-issue stage top level
// Slot selection, scheduling, two pipe trackers, the 2W4R register
// file and per-slot operand forwarding
`timescale 1ns/100ps

module issue_top
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  issue_pkg::fetch_word_t   fetch0_i,
    input  issue_pkg::fetch_word_t   fetch1_i,
    input  logic [isa_pkg::XLEN-1:0] exec0_result_i,
    input  logic [isa_pkg::XLEN-1:0] exec1_result_i,
    input  logic [isa_pkg::XLEN-1:0] mem_result_i,
    output logic                     fetch0_accept_o,
    output logic                     fetch1_accept_o,
    output logic                     redirect_o,
    output logic [isa_pkg::XLEN-1:0] redirect_pc_o,
    output issue_pkg::issue_op_t     issue0_o,
    output issue_pkg::issue_op_t     issue1_o
);

    issue_pkg::slot_op_t           slot_a;
    issue_pkg::slot_op_t           slot_b;
    logic                          issue_a;
    logic                          issue_b;
    issue_pkg::stage_t             p0_e1, p0_e2, p0_wb;
    issue_pkg::stage_t             p1_e1, p1_e2, p1_wb;
    logic [isa_pkg::REG_IDX_W-1:0] a_ra_idx, a_rb_idx, b_ra_idx, b_rb_idx;
    logic [isa_pkg::XLEN-1:0]      rf_a_ra, rf_a_rb, rf_b_ra, rf_b_rb;
    logic [isa_pkg::XLEN-1:0]      a_ra_val, a_rb_val, b_ra_val, b_rb_val;

    //----------------------------------------
    // Front end and scheduling
    //----------------------------------------
    slot_select u_slot_select (
        .clk_i(clk_i), .rst_i(rst_i), .fetch0_i(fetch0_i), .fetch1_i(fetch1_i),
        .issue_a_i(issue_a), .issue_b_i(issue_b), .slot_a_o(slot_a), .slot_b_o(slot_b),
        .fetch0_accept_o(fetch0_accept_o), .fetch1_accept_o(fetch1_accept_o),
        .redirect_o(redirect_o), .redirect_pc_o(redirect_pc_o)
    );

    issue_sched u_sched (
        .slot_a_i(slot_a), .slot_b_i(slot_b), .p0_e1_i(p0_e1), .p0_e2_i(p0_e2),
        .p1_e1_i(p1_e1), .p1_e2_i(p1_e2), .issue_a_o(issue_a), .issue_b_o(issue_b)
    );

    // Pipe 0 carries slot A, pipe 1 slot B
    pipe_tracker u_pipe0 (
        .clk_i(clk_i), .rst_i(rst_i), .issue_i(issue_a), .op_i(slot_a),
        .e1_result_i(exec0_result_i), .mem_result_i(mem_result_i),
        .e1_o(p0_e1), .e2_o(p0_e2), .wb_o(p0_wb)
    );

    pipe_tracker u_pipe1 (
        .clk_i(clk_i), .rst_i(rst_i), .issue_i(issue_b), .op_i(slot_b),
        .e1_result_i(exec1_result_i), .mem_result_i(mem_result_i),
        .e1_o(p1_e1), .e2_o(p1_e2), .wb_o(p1_wb)
    );

    //----------------------------------------
    // Operands
    //----------------------------------------
    assign a_ra_idx = slot_a.instr[isa_pkg::RA_LSB +: isa_pkg::REG_IDX_W];
    assign a_rb_idx = slot_a.instr[isa_pkg::RB_LSB +: isa_pkg::REG_IDX_W];
    assign b_ra_idx = slot_b.instr[isa_pkg::RA_LSB +: isa_pkg::REG_IDX_W];
    assign b_rb_idx = slot_b.instr[isa_pkg::RB_LSB +: isa_pkg::REG_IDX_W];

    regfile u_regfile (
        .clk_i(clk_i), .rst_i(rst_i),
        .wr0_en_i(p0_wb.valid && p0_wb.writes_rd), .wr1_en_i(p1_wb.valid && p1_wb.writes_rd),
        .wr0_idx_i(p0_wb.rd), .wr1_idx_i(p1_wb.rd),
        .wr0_data_i(p0_wb.result), .wr1_data_i(p1_wb.result),
        .ra0_idx_i(a_ra_idx), .rb0_idx_i(a_rb_idx), .ra1_idx_i(b_ra_idx), .rb1_idx_i(b_rb_idx),
        .ra0_value_o(rf_a_ra), .rb0_value_o(rf_a_rb),
        .ra1_value_o(rf_b_ra), .rb1_value_o(rf_b_rb)
    );

    operand_bypass u_bypass_a (
        .ra_idx_i(a_ra_idx), .rb_idx_i(a_rb_idx), .rf_ra_i(rf_a_ra), .rf_rb_i(rf_a_rb),
        .p0_e1_i(p0_e1), .p0_e2_i(p0_e2), .p0_wb_i(p0_wb),
        .p1_e1_i(p1_e1), .p1_e2_i(p1_e2), .p1_wb_i(p1_wb),
        .exec0_result_i(exec0_result_i), .exec1_result_i(exec1_result_i),
        .ra_value_o(a_ra_val), .rb_value_o(a_rb_val)
    );

    operand_bypass u_bypass_b (
        .ra_idx_i(b_ra_idx), .rb_idx_i(b_rb_idx), .rf_ra_i(rf_b_ra), .rf_rb_i(rf_b_rb),
        .p0_e1_i(p0_e1), .p0_e2_i(p0_e2), .p0_wb_i(p0_wb),
        .p1_e1_i(p1_e1), .p1_e2_i(p1_e2), .p1_wb_i(p1_wb),
        .exec0_result_i(exec0_result_i), .exec1_result_i(exec1_result_i),
        .ra_value_o(b_ra_val), .rb_value_o(b_rb_val)
    );

    //----------------------------------------
    // Issue outputs
    //----------------------------------------
    always_comb
    begin
        issue0_o.valid    = issue_a;
        issue0_o.instr    = slot_a.instr;
        issue0_o.pc       = slot_a.pc;
        issue0_o.ra_value = a_ra_val;
        issue0_o.rb_value = a_rb_val;

        issue1_o.valid    = issue_b;
        issue1_o.instr    = slot_b.instr;
        issue1_o.pc       = slot_b.pc;
        issue1_o.ra_value = b_ra_val;
        issue1_o.rb_value = b_rb_val;
    end

endmodule

// File: hw/operand_bypass.sv
// Operand forwarding for one issue slot
// Picks the newest value of each source register from E1, E2 and WB
// of both pipes, falling back to the register file
`timescale 1ns/100ps

module operand_bypass
(
    input  logic [isa_pkg::REG_IDX_W-1:0] ra_idx_i,
    input  logic [isa_pkg::REG_IDX_W-1:0] rb_idx_i,
    input  logic [isa_pkg::XLEN-1:0]      rf_ra_i,
    input  logic [isa_pkg::XLEN-1:0]      rf_rb_i,
    input  issue_pkg::stage_t             p0_e1_i,
    input  issue_pkg::stage_t             p0_e2_i,
    input  issue_pkg::stage_t             p0_wb_i,
    input  issue_pkg::stage_t             p1_e1_i,
    input  issue_pkg::stage_t             p1_e2_i,
    input  issue_pkg::stage_t             p1_wb_i,
    input  logic [isa_pkg::XLEN-1:0]      exec0_result_i,
    input  logic [isa_pkg::XLEN-1:0]      exec1_result_i,
    output logic [isa_pkg::XLEN-1:0]      ra_value_o,
    output logic [isa_pkg::XLEN-1:0]      rb_value_o
);

    function automatic logic hit(
        input issue_pkg::stage_t             st,
        input logic [isa_pkg::REG_IDX_W-1:0] idx
    );
        return st.valid && st.writes_rd && (st.rd == idx);
    endfunction

    // Later checks override earlier ones, newest stage last
    function automatic logic [isa_pkg::XLEN-1:0] forward(
        input logic [isa_pkg::REG_IDX_W-1:0] idx,
        input logic [isa_pkg::XLEN-1:0]      rf_value
    );
        logic [isa_pkg::XLEN-1:0] value;
        value = rf_value;
        if (hit(p0_wb_i, idx)) value = p0_wb_i.result;
        if (hit(p1_wb_i, idx)) value = p1_wb_i.result;
        if (hit(p0_e2_i, idx)) value = p0_e2_i.result;
        if (hit(p1_e2_i, idx)) value = p1_e2_i.result;
        if (hit(p0_e1_i, idx)) value = exec0_result_i;
        if (hit(p1_e1_i, idx)) value = exec1_result_i;
        if (idx == '0)
            value = '0;
        return value;
    endfunction

    always_comb
    begin
        ra_value_o = forward(ra_idx_i, rf_ra_i);
        rb_value_o = forward(rb_idx_i, rf_rb_i);
    end

endmodule

// File: hw/pipe_tracker.sv
// Execution pipe tracker
// Follows one issue pipe through E1, E2 and WB. The ALU result is
// taken during E1 and load data during E2, then both ride to WB.
`timescale 1ns/100ps

module pipe_tracker
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     issue_i,
    input  issue_pkg::slot_op_t      op_i,
    input  logic [isa_pkg::XLEN-1:0] e1_result_i,
    input  logic [isa_pkg::XLEN-1:0] mem_result_i,
    output issue_pkg::stage_t        e1_o,
    output issue_pkg::stage_t        e2_o,
    output issue_pkg::stage_t        wb_o
);

    logic [isa_pkg::REG_IDX_W-1:0] op_rd;
    logic                          op_load;
    logic                          op_writes;

    logic                          e1_valid_q;
    logic                          e1_load_q;
    logic                          e1_writes_q;
    logic [isa_pkg::REG_IDX_W-1:0] e1_rd_q;
    issue_pkg::stage_t             e2_q;
    issue_pkg::stage_t             wb_q;

    // Destination decode, r0 never counts as written
    assign op_rd     = op_i.instr[isa_pkg::RD_LSB +: isa_pkg::REG_IDX_W];
    assign op_load   = (op_i.iclass == isa_pkg::CLASS_LOAD);
    assign op_writes = (op_i.iclass != isa_pkg::CLASS_STORE) && (op_rd != '0);

    //----------------------------------------
    // Stage registers
    //----------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            e1_valid_q  <= 1'b0;
            e1_load_q   <= 1'b0;
            e1_writes_q <= 1'b0;
            e1_rd_q     <= '0;
            e2_q        <= '0;
            wb_q        <= '0;
        end
        else
        begin
            e1_valid_q  <= issue_i;
            e1_load_q   <= issue_i && op_load;
            e1_writes_q <= issue_i && op_writes;
            e1_rd_q     <= op_rd;

            e2_q.valid     <= e1_valid_q;
            e2_q.is_load   <= e1_load_q;
            e2_q.writes_rd <= e1_writes_q;
            e2_q.rd        <= e1_rd_q;
            // ALU result sampled at the end of E1
            e2_q.result    <= e1_result_i;

            wb_q <= e2_o;
        end
    end

    assign e1_o = '{valid:     e1_valid_q,
                    is_load:   e1_load_q,
                    writes_rd: e1_writes_q,
                    rd:        e1_rd_q,
                    result:    e1_result_i};

    always_comb
    begin
        e2_o = e2_q;
        // Load data is live from memory during E2
        if (e2_q.is_load)
            e2_o.result = mem_result_i;
    end

    assign wb_o = wb_q;

endmodule

// File: hw/regfile.sv
// Integer register file
// 31 entries with two write ports and four read ports, r0 reads as
// zero. Writes land at the clock edge, reads are combinational.
`timescale 1ns/100ps

module regfile
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        wr0_en_i,
    input  logic        wr1_en_i,
    input  logic [4:0]  wr0_idx_i,
    input  logic [4:0]  wr1_idx_i,
    input  logic [31:0] wr0_data_i,
    input  logic [31:0] wr1_data_i,
    input  logic [4:0]  ra0_idx_i,
    input  logic [4:0]  rb0_idx_i,
    input  logic [4:0]  ra1_idx_i,
    input  logic [4:0]  rb1_idx_i,
    output logic [31:0] ra0_value_o,
    output logic [31:0] rb0_value_o,
    output logic [31:0] ra1_value_o,
    output logic [31:0] rb1_value_o
);

    logic [31:0] regs_q [1:31];

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int i = 1; i < 32; i++)
                regs_q[i] <= '0;
        end
        else
        begin
            if (wr0_en_i && (wr0_idx_i != 5'd0))
                regs_q[wr0_idx_i] <= wr0_data_i;
            // Port 1 holds the younger op and wins
            if (wr1_en_i && (wr1_idx_i != 5'd0))
                regs_q[wr1_idx_i] <= wr1_data_i;
        end
    end

    function automatic logic [31:0] rd_reg(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : regs_q[idx];
    endfunction

    always_comb
    begin
        ra0_value_o = rd_reg(ra0_idx_i);
        rb0_value_o = rd_reg(rb0_idx_i);
        ra1_value_o = rd_reg(ra1_idx_i);
        rb1_value_o = rd_reg(rb1_idx_i);
    end

endmodule

// File: hw/slot_select.sv
// Issue slot selection
// Tracks the expected PC, matches both fetch words against it and
// steers them into slot A and slot B. Raises a one-cycle redirect
// when neither valid word is at the expected PC.
`timescale 1ns/100ps

module slot_select
(
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  issue_pkg::fetch_word_t   fetch0_i,
    input  issue_pkg::fetch_word_t   fetch1_i,
    input  logic                     issue_a_i,
    input  logic                     issue_b_i,
    output issue_pkg::slot_op_t      slot_a_o,
    output issue_pkg::slot_op_t      slot_b_o,
    output logic                     fetch0_accept_o,
    output logic                     fetch1_accept_o,
    output logic                     redirect_o,
    output logic [isa_pkg::XLEN-1:0] redirect_pc_o
);

    logic [isa_pkg::XLEN-1:0] pc_q;
    logic                     match0;
    logic                     match1;

    function automatic issue_pkg::slot_op_t to_slot(input issue_pkg::fetch_word_t w);
        issue_pkg::slot_op_t s;
        s.valid  = w.valid;
        s.instr  = w.instr;
        s.pc     = w.pc;
        s.iclass = w.iclass;
        return s;
    endfunction

    //----------------------------------------
    // Expected PC
    //----------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pc_q <= issue_pkg::RESET_PC;
        else if (issue_b_i)
            pc_q <= pc_q + (issue_pkg::INSTR_BYTES << 1);
        else if (issue_a_i)
            pc_q <= pc_q + issue_pkg::INSTR_BYTES;
    end

    assign match0 = fetch0_i.valid && (fetch0_i.pc == pc_q);
    assign match1 = fetch1_i.valid && (fetch1_i.pc == pc_q);

    //----------------------------------------
    // Slot steering
    //----------------------------------------
    always_comb
    begin
        slot_a_o = '0;
        slot_b_o = '0;
        if (match0)
        begin
            slot_a_o = to_slot(fetch0_i);
            slot_b_o = to_slot(fetch1_i);
        end
        // Word 1 alone is at the expected PC, so it moves to slot A
        else if (match1)
            slot_a_o = to_slot(fetch1_i);
    end

    // Neither word is where execution continues
    assign redirect_o    = !match0 && !match1 && (fetch0_i.valid || fetch1_i.valid);
    assign redirect_pc_o = pc_q;

    // Word 0 is dropped when only word 1 matches
    assign fetch0_accept_o = (match0 && issue_a_i) || (!match0 && match1);
    assign fetch1_accept_o = (!match0 && match1 && issue_a_i) || issue_b_i;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module issue_tb -f filelist.f \
    -Mdir obj_dir -o issue_sim > build.log 2>&1 &&
    ./obj_dir/issue_sim > sim.log 2>&1 ||
    echo "Build or simulation did not complete, see build.log" >> sim.log
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log
then
    echo "Result: FAIL"
    exit 1
fi
echo "Result: PASS"

// File: tests/issue_assert.sv
// Issue stage output assertions
// Redirect and issue exclusion, slot ordering and quiet outputs
// while reset is held
`timescale 1ns/100ps

module issue_assert
(
    input logic                 clk_i,
    input logic                 rst_i,
    input logic                 fetch0_accept_o,
    input logic                 fetch1_accept_o,
    input logic                 redirect_o,
    input issue_pkg::issue_op_t issue0_o,
    input issue_pkg::issue_op_t issue1_o
);

    // Nothing issues in a redirect cycle
    redirect_no_issue: assert property (
        @(posedge clk_i) disable iff (rst_i)
        redirect_o |-> !(issue0_o.valid || issue1_o.valid)
    ) else $error("redirect raised together with an issue valid");

    // Slot 1 never issues alone
    issue1_needs_issue0: assert property (
        @(posedge clk_i) disable iff (rst_i)
        issue1_o.valid |-> issue0_o.valid
    ) else $error("issue1 valid without issue0 valid");

    quiet_in_reset: assert property (
        @(posedge clk_i)
        rst_i |-> !(fetch0_accept_o || fetch1_accept_o || redirect_o ||
                    issue0_o.valid || issue1_o.valid)
    ) else $error("output active while reset is held");

endmodule

bind issue_top issue_assert assert0 (
    .clk_i(clk_i), .rst_i(rst_i),
    .fetch0_accept_o(fetch0_accept_o), .fetch1_accept_o(fetch1_accept_o),
    .redirect_o(redirect_o), .issue0_o(issue0_o), .issue1_o(issue1_o)
);

// File: tests/issue_tb.sv
// Issue stage testbench
// Applies a table of fetch pairs, one row per cycle, and checks the
// accepts, issue valids, redirect and issued operands against a
// reference register model that follows the fixed E1/E2/WB timing
`timescale 1ns/100ps

module issue_tb;

    localparam int          PERIOD       = 8;
    localparam int          RESET_CYCLES = 4;
    localparam int          NROWS        = 23;
    localparam logic [31:0] SEED         = 32'h50218631;

    localparam isa_pkg::instr_class_e ALU = isa_pkg::CLASS_ALU;
    localparam isa_pkg::instr_class_e LD  = isa_pkg::CLASS_LOAD;
    localparam isa_pkg::instr_class_e ST  = isa_pkg::CLASS_STORE;

    // One cycle of stimulus, word 1 sits at pc + 4
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        isa_pkg::instr_class_e c0;
        logic [4:0]            rd0;
        logic [4:0]            ra0;
        logic [4:0]            rb0;
        isa_pkg::instr_class_e c1;
        logic [4:0]            rd1;
        logic [4:0]            ra1;
        logic [4:0]            rb1;
        logic [4:0]            expect_bits;  // acc0 acc1 iss0 iss1 redirect
    } row_t;

    logic                   clk_i;
    logic                   rst_i;
    issue_pkg::fetch_word_t fetch0_i;
    issue_pkg::fetch_word_t fetch1_i;
    logic [31:0]            exec0_result_i;
    logic [31:0]            exec1_result_i;
    logic [31:0]            mem_result_i;
    logic                   fetch0_accept_o;
    logic                   fetch1_accept_o;
    logic                   redirect_o;
    logic [31:0]            redirect_pc_o;
    issue_pkg::issue_op_t   issue0_o;
    issue_pkg::issue_op_t   issue1_o;

    row_t        rows [NROWS];
    string       names [NROWS];
    int          n_rows;
    string       cur_name;
    logic [31:0] ref_regs [32];
    // Destination registers due for write-back, indexed by cycle (0 means none)
    logic [4:0]  a0_due [NROWS+3];
    logic [4:0]  a1_due [NROWS+3];
    logic [4:0]  ld_due [NROWS+3];
    logic [31:0] lfsr_q;
    logic [31:0] exp_pc;
    int          errors;
    int          checks;

    issue_top dut0 (
        .clk_i(clk_i), .rst_i(rst_i), .fetch0_i(fetch0_i), .fetch1_i(fetch1_i),
        .exec0_result_i(exec0_result_i), .exec1_result_i(exec1_result_i),
        .mem_result_i(mem_result_i), .fetch0_accept_o(fetch0_accept_o),
        .fetch1_accept_o(fetch1_accept_o), .redirect_o(redirect_o),
        .redirect_pc_o(redirect_pc_o), .issue0_o(issue0_o), .issue1_o(issue1_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(PERIOD/2) clk_i = ~clk_i;
    end

    initial
    begin
        #((NROWS + RESET_CYCLES + 10) * PERIOD);
        $display("Watchdog expired before the table was applied");
        $display("SOME TESTS FAILED");
        $finish;
    end

    //----------------------------------------
    // Helpers
    //----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] encode(input isa_pkg::instr_class_e c,
                                           input logic [4:0] rd, ra, rb);
        logic [31:0] w;
        w = '0;
        case (c)
            isa_pkg::CLASS_LOAD:  w[6:0] = 7'h03;
            isa_pkg::CLASS_STORE: w[6:0] = 7'h23;
            default:              w[6:0] = 7'h33;
        endcase
        w[isa_pkg::RD_LSB +: 5] = rd;
        w[isa_pkg::RA_LSB +: 5] = ra;
        w[isa_pkg::RB_LSB +: 5] = rb;
        return w;
    endfunction

    task automatic add_row(input string name, input logic v, input logic [31:0] pc,
                           input isa_pkg::instr_class_e c0, input int rd0, ra0, rb0,
                           input isa_pkg::instr_class_e c1, input int rd1, ra1, rb1,
                           input logic [4:0] expect_bits);
        rows[n_rows] = {v, pc, c0, 5'(rd0), 5'(ra0), 5'(rb0),
                        c1, 5'(rd1), 5'(ra1), 5'(rb1), expect_bits};
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Error: %s %s expected %b actual %b", cur_name, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Error: %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic drive_row(input row_t r);
        fetch0_i.valid  = r.valid;
        fetch0_i.pc     = r.pc;
        fetch0_i.iclass = r.c0;
        fetch0_i.instr  = encode(r.c0, r.rd0, r.ra0, r.rb0);
        fetch1_i.valid  = r.valid;
        fetch1_i.pc     = r.pc + 32'd4;
        fetch1_i.iclass = r.c1;
        fetch1_i.instr  = encode(r.c1, r.rd1, r.ra1, r.rb1);
    endtask

    // Results land in program order: load first, then pipe 0, then pipe 1
    task automatic retire_due(input int c);
        if (ld_due[c] != 5'd0)
            ref_regs[ld_due[c]] = mem_result_i;
        if (a0_due[c] != 5'd0)
            ref_regs[a0_due[c]] = exec0_result_i;
        if (a1_due[c] != 5'd0)
            ref_regs[a1_due[c]] = exec1_result_i;
    endtask

    task automatic check_row(input row_t r, input int c);
        isa_pkg::instr_class_e a_cls;
        logic [4:0]            a_rd;
        logic [4:0]            a_ra;
        logic [4:0]            a_rb;
        check_bit("fetch0_accept", r.expect_bits[4], fetch0_accept_o);
        check_bit("fetch1_accept", r.expect_bits[3], fetch1_accept_o);
        check_bit("issue0.valid", r.expect_bits[2], issue0_o.valid);
        check_bit("issue1.valid", r.expect_bits[1], issue1_o.valid);
        check_bit("redirect", r.expect_bits[0], redirect_o);
        if (r.expect_bits[0])
            check_word("redirect_pc", exp_pc, redirect_pc_o);
        // Slot A holds word 1 when word 0 is off the expected PC
        a_cls = (r.pc == exp_pc) ? r.c0 : r.c1;
        a_rd  = (r.pc == exp_pc) ? r.rd0 : r.rd1;
        a_ra  = (r.pc == exp_pc) ? r.ra0 : r.ra1;
        a_rb  = (r.pc == exp_pc) ? r.rb0 : r.rb1;
        if (r.expect_bits[2])
        begin
            check_word("issue0.pc", exp_pc, issue0_o.pc);
            check_word("issue0.instr", encode(a_cls, a_rd, a_ra, a_rb), issue0_o.instr);
            check_word("issue0.ra", ref_regs[a_ra], issue0_o.ra_value);
            check_word("issue0.rb", ref_regs[a_rb], issue0_o.rb_value);
            if (a_cls == ALU)
                a0_due[c+1] = a_rd;
            else if (a_cls == LD)
                ld_due[c+2] = a_rd;
        end
        if (r.expect_bits[1])
        begin
            check_word("issue1.pc", exp_pc + 32'd4, issue1_o.pc);
            check_word("issue1.instr", encode(r.c1, r.rd1, r.ra1, r.rb1), issue1_o.instr);
            check_word("issue1.ra", ref_regs[r.ra1], issue1_o.ra_value);
            check_word("issue1.rb", ref_regs[r.rb1], issue1_o.rb_value);
            a1_due[c+1] = r.rd1;
        end
        exp_pc = exp_pc + (r.expect_bits[2] ? 32'd4 : 32'd0) + (r.expect_bits[1] ? 32'd4 : 32'd0);
    endtask

    //----------------------------------------
    // Stimulus table
    //----------------------------------------
    task automatic fill_rows();
        add_row("dual_alu",       1'b1, 32'd0,   ALU, 1, 0, 0,   ALU, 2, 0, 0,    5'b11110);
        add_row("pair_dep",       1'b1, 32'd8,   ALU, 3, 1, 2,   ALU, 4, 3, 1,    5'b10100);
        add_row("pair_load_b",    1'b1, 32'd12,  ALU, 4, 3, 1,   LD, 5, 1, 0,     5'b10100);
        add_row("load_a",         1'b1, 32'd16,  LD, 5, 1, 0,    ALU, 6, 5, 2,    5'b10100);
        add_row("load_use_hold",  1'b1, 32'd20,  ALU, 6, 5, 2,   ALU, 7, 2, 1,    5'b00000);
        add_row("load_use_issue", 1'b1, 32'd20,  ALU, 6, 5, 2,   ALU, 7, 2, 1,    5'b11110);
        add_row("store_a",        1'b1, 32'd28,  ST, 0, 6, 7,    ALU, 8, 0, 0,    5'b10100);
        add_row("store_b",        1'b1, 32'd32,  ALU, 8, 3, 4,   ST, 0, 3, 1,     5'b10100);
        add_row("redirect",       1'b1, 32'd100, ALU, 20, 1, 2,  ALU, 21, 1, 2,   5'b00001);
        add_row("resume",         1'b1, 32'd36,  ST, 0, 3, 1,    ALU, 9, 1, 2,    5'b10100);
        add_row("slot1_only",     1'b1, 32'd36,  ST, 0, 3, 1,    ALU, 9, 1, 2,    5'b11100);
        add_row("dual_bypass",    1'b1, 32'd44,  ALU, 10, 9, 0,  ALU, 11, 0, 7,   5'b11110);
        add_row("load_alu_pair",  1'b1, 32'd52,  LD, 12, 10, 0,  ALU, 13, 11, 11, 5'b11110);
        add_row("load_use_hold2", 1'b1, 32'd60,  ALU, 14, 12, 0, ALU, 15, 12, 14, 5'b00000);
        add_row("load_use_dep",   1'b1, 32'd60,  ALU, 14, 12, 0, ALU, 15, 12, 14, 5'b10100);
        add_row("dual_rewrite",   1'b1, 32'd64,  ALU, 15, 12, 14, ALU, 1, 0, 0,   5'b11110);
        add_row("r0_write",       1'b1, 32'd72,  ALU, 0, 1, 0,   ALU, 16, 0, 0,   5'b11110);
        add_row("r0_read",        1'b1, 32'd80,  ALU, 17, 0, 16, ALU, 18, 1, 0,   5'b11110);
        add_row("idle",           1'b0, 32'd0,   ALU, 0, 0, 0,   ALU, 0, 0, 0,    5'b00000);
        add_row("idle",           1'b0, 32'd0,   ALU, 0, 0, 0,   ALU, 0, 0, 0,    5'b00000);
        add_row("idle",           1'b0, 32'd0,   ALU, 0, 0, 0,   ALU, 0, 0, 0,    5'b00000);
        add_row("rf_read",        1'b1, 32'd88,  ALU, 0, 8, 5,   ALU, 0, 12, 17,  5'b11110);
        add_row("idle",           1'b0, 32'd0,   ALU, 0, 0, 0,   ALU, 0, 0, 0,    5'b00000);
    endtask

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial
    begin
        logic [31:0] value;
        rst_i          = 1'b1;
        fetch0_i       = '0;
        fetch1_i       = '0;
        exec0_result_i = '0;
        exec1_result_i = '0;
        mem_result_i   = '0;
        lfsr_q         = SEED;
        exp_pc         = issue_pkg::RESET_PC;
        errors         = 0;
        checks         = 0;
        n_rows         = 0;
        for (int k = 0; k < 32; k++)
            ref_regs[k] = '0;
        for (int k = 0; k < NROWS + 3; k++)
        begin
            a0_due[k] = '0;
            a1_due[k] = '0;
            ld_due[k] = '0;
        end
        fill_rows();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        for (int i = 0; i < NROWS; i++)
        begin
            @(negedge clk_i);
            cur_name = names[i];
            drive_row(rows[i]);
            take_word(value);
            exec0_result_i = value;
            take_word(value);
            exec1_result_i = value;
            take_word(value);
            mem_result_i = value;
            retire_due(i);
            // Outputs are combinational, settled well before the next edge
            #2;
            check_row(rows[i], i);
        end

        @(negedge clk_i);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
